/* hdl/soc_pkg.sv */
// system bus package
// bus widths, memory map, startup count, bus enums and the AHB-Lite
// request and response structs shared by the whole system
package soc_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int ADDR_W        = 32;
    localparam int DATA_W        = 32;
    localparam int STRB_W        = DATA_W / 8;
    localparam int RAM_AW        = 12;
    localparam int RAM_WORDS     = 2 ** (RAM_AW - 2);
    localparam int GPIO_W        = 16;
    localparam int GPIO_OFF_W    = 12;

    // ------------------------------
    // memory map
    // ------------------------------
    // ram at 0x200x_xxxx, gpio at 0x4000_0xxx
    localparam logic [11:0] RAM_BASE  = 12'h200;
    localparam logic [19:0] GPIO_BASE = 20'h40000;

    localparam logic [GPIO_OFF_W-1:0] GPIO_DATA    = 12'h000;
    localparam logic [GPIO_OFF_W-1:0] GPIO_DATAOUT = 12'h004;
    localparam logic [GPIO_OFF_W-1:0] GPIO_OUTEN   = 12'h010;

    // bus held in reset for this many xtal cycles after NRST
    localparam int STARTUP_CYCLES = 28;
    localparam int STARTUP_CNT_W  = $clog2(STARTUP_CYCLES + 1);

    // ------------------------------
    // bus encodings
    // ------------------------------
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_e;

    // owner of the current data phase
    typedef enum logic [1:0] {
        SLV_RAM  = 2'b00,
        SLV_GPIO = 2'b01,
        SLV_DEF  = 2'b10
    } slave_e;

    typedef struct packed {
        logic [ADDR_W-1:0] haddr;
        htrans_e           htrans;
        hsize_e            hsize;
        logic              hwrite;
        logic [DATA_W-1:0] hwdata;
    } ahb_req_t;

    // hresp set means ERROR
    typedef struct packed {
        logic [DATA_W-1:0] hrdata;
        logic              hready;
        logic              hresp;
    } ahb_rsp_t;

endpackage

/* hdl/startup_seq.sv */
// power-on startup sequencer
// counts xtal cycles after NRST and then releases the bus by raising run
module startup_seq
    import soc_pkg::*;
(
    input  logic XTAL,
    input  logic NRST,
    output logic run
);

    logic [STARTUP_CNT_W-1:0] cnt;

    // counter stops at the threshold and run latches high on the last step
    always_ff @(posedge XTAL or negedge NRST) begin
        if (!NRST) begin
            cnt <= '0;
            run <= 1'b0;
        end else begin
            if (cnt < STARTUP_CNT_W'(STARTUP_CYCLES)) begin
                cnt <= cnt + 1'b1;
            end
            if (cnt == STARTUP_CNT_W'(STARTUP_CYCLES - 1)) begin
                run <= 1'b1;
            end
        end
    end

    // ------------------------------
    // checks
    // ------------------------------
    // bus reset is never re-applied without a power-on reset
    a_run_sticky : assert property (
        @(posedge XTAL) disable iff (!NRST)
        run |=> run
    ) else $error("run dropped without NRST");

endmodule

/* hdl/ahb_interconnect.sv */
// system bus interconnect
// decodes the memory map, remembers the slave owning the data phase
// and returns that slave's response to the master
module ahb_interconnect
    import soc_pkg::*;
(
    input  logic     XTAL,
    input  logic     run,
    input  ahb_req_t bus_req,
    output logic     sel_ram,
    output logic     sel_gpio,
    output logic     sel_def,
    input  ahb_rsp_t rsp_ram,
    input  ahb_rsp_t rsp_gpio,
    input  ahb_rsp_t rsp_def,
    output logic     hready,
    output ahb_rsp_t bus_rsp
);

    slave_e slv_d;
    slave_e slv_q;

    // ------------------------------
    // address decode
    // ------------------------------
    assign sel_ram  = (bus_req.haddr[ADDR_W-1:20] == RAM_BASE);
    assign sel_gpio = (bus_req.haddr[ADDR_W-1:12] == GPIO_BASE);

    // anything unmapped goes to the default slave
    assign sel_def  = !(sel_ram || sel_gpio);

    always_comb begin
        if (sel_ram) begin
            slv_d = SLV_RAM;
        end else if (sel_gpio) begin
            slv_d = SLV_GPIO;
        end else begin
            slv_d = SLV_DEF;
        end
    end

    // ram owns the data phase out of reset and answers ready
    always_ff @(posedge XTAL or negedge run) begin
        if (!run) begin
            slv_q <= SLV_RAM;
        end else if (hready) begin
            slv_q <= slv_d;
        end
    end

    // ------------------------------
    // response mux
    // ------------------------------
    always_comb begin
        case (slv_q)
            SLV_RAM:  bus_rsp = rsp_ram;
            SLV_GPIO: bus_rsp = rsp_gpio;
            default:  bus_rsp = rsp_def;
        endcase
    end

    assign hready = bus_rsp.hready;

    // ------------------------------
    // checks
    // ------------------------------
    // ram and gpio ranges must not overlap
    a_sel_onehot : assert property (
        @(posedge XTAL) disable iff (!run)
        $onehot0({sel_ram, sel_gpio, sel_def})
    ) else $error("more than one slave selected");

endmodule

/* hdl/ahb_ram.sv */
// zero wait state ram on the system bus
// word array with byte, halfword and word writes; reads are served
// in the data phase from the address taken in the address phase
module ahb_ram
    import soc_pkg::*;
(
    input  logic     XTAL,
    input  logic     run,
    input  logic     sel,
    input  logic     hready,
    input  ahb_req_t bus_req,
    output ahb_rsp_t rsp
);

    logic [DATA_W-1:0]   mem [RAM_WORDS];

    logic                xfer;
    logic [STRB_W-1:0]   lane_d;
    logic                we_q;
    logic [STRB_W-1:0]   lane_q;
    logic [RAM_AW-3:0]   addr_q;

    assign xfer = sel && hready &&
                  (bus_req.htrans == NONSEQ || bus_req.htrans == SEQ);

    // byte lanes from size and low address bits
    always_comb begin
        case (bus_req.hsize)
            BYTE:    lane_d = STRB_W'(1) << bus_req.haddr[1:0];
            HALF:    lane_d = bus_req.haddr[1] ? 4'b1100 : 4'b0011;
            default: lane_d = '1;
        endcase
    end

    // ------------------------------
    // address phase
    // ------------------------------
    always_ff @(posedge XTAL or negedge run) begin
        if (!run) begin
            we_q   <= 1'b0;
            lane_q <= '0;
            addr_q <= '0;
        end else if (hready) begin
            we_q <= xfer && bus_req.hwrite;
            if (xfer) begin
                lane_q <= lane_d;
                addr_q <= bus_req.haddr[RAM_AW-1:2];
            end
        end
    end

    // ------------------------------
    // data phase
    // ------------------------------
    // write commits at the end of the data phase
    always_ff @(posedge XTAL) begin
        for (int i = 0; i < STRB_W; i++) begin
            if (we_q && lane_q[i]) begin
                mem[addr_q][8*i +: 8] <= bus_req.hwdata[8*i +: 8];
            end
        end
    end

    always_comb begin
        rsp.hrdata = mem[addr_q];
        rsp.hready = 1'b1;
        rsp.hresp  = 1'b0;
    end

endmodule

/* hdl/ahb_gpio.sv */
// 16-bit gpio on the system bus
// data-out and output-enable registers plus a two stage input sync
module ahb_gpio
    import soc_pkg::*;
(
    input  logic              XTAL,
    input  logic              run,
    input  logic              sel,
    input  logic              hready,
    input  ahb_req_t          bus_req,
    output ahb_rsp_t          rsp,
    input  logic [GPIO_W-1:0] gpio_in,
    output logic [GPIO_W-1:0] gpio_out,
    output logic [GPIO_W-1:0] gpio_oe
);

    logic                  xfer;
    logic                  wr_q;
    logic [GPIO_OFF_W-1:0] off_q;
    logic [GPIO_W-1:0]     dout_q;
    logic [GPIO_W-1:0]     oen_q;
    logic [GPIO_W-1:0]     sync1_q;
    logic [GPIO_W-1:0]     sync2_q;

    assign xfer = sel && hready &&
                  (bus_req.htrans == NONSEQ || bus_req.htrans == SEQ);

    // ------------------------------
    // address phase
    // ------------------------------
    always_ff @(posedge XTAL or negedge run) begin
        if (!run) begin
            wr_q  <= 1'b0;
            off_q <= '0;
        end else if (hready) begin
            wr_q <= xfer && bus_req.hwrite;
            if (xfer) begin
                off_q <= bus_req.haddr[GPIO_OFF_W-1:0];
            end
        end
    end

    // registers written at the end of the data phase
    always_ff @(posedge XTAL or negedge run) begin
        if (!run) begin
            dout_q <= '0;
            oen_q  <= '0;
        end else if (wr_q) begin
            case (off_q)
                GPIO_DATAOUT: dout_q <= bus_req.hwdata[GPIO_W-1:0];
                GPIO_OUTEN:   oen_q  <= bus_req.hwdata[GPIO_W-1:0];
                default:      ;
            endcase
        end
    end

    // pin input sync
    always_ff @(posedge XTAL or negedge run) begin
        if (!run) begin
            sync1_q <= '0;
            sync2_q <= '0;
        end else begin
            sync1_q <= gpio_in;
            sync2_q <= sync1_q;
        end
    end

    // ------------------------------
    // read data
    // ------------------------------
    always_comb begin
        rsp.hrdata = '0;
        rsp.hready = 1'b1;
        rsp.hresp  = 1'b0;
        case (off_q)
            GPIO_DATA:    rsp.hrdata[GPIO_W-1:0] = sync2_q;
            GPIO_DATAOUT: rsp.hrdata[GPIO_W-1:0] = dout_q;
            GPIO_OUTEN:   rsp.hrdata[GPIO_W-1:0] = oen_q;
            default:      rsp.hrdata = '0;
        endcase
    end

    assign gpio_out = dout_q;
    assign gpio_oe  = oen_q;

endmodule

/* hdl/ahb_default_slave.sv */
// default slave for unmapped addresses
// active transfers get a two cycle ERROR, idle and busy get OKAY
module ahb_default_slave
    import soc_pkg::*;
(
    input  logic     XTAL,
    input  logic     run,
    input  logic     sel,
    input  logic     hready,
    input  ahb_req_t bus_req,
    output ahb_rsp_t rsp
);

    typedef enum logic [1:0] {
        IDLE = 2'b00,
        ERR1 = 2'b01,
        ERR2 = 2'b10
    } state_e;

    state_e state;
    state_e state_nxt;
    logic   xfer;

    assign xfer = sel && hready &&
                  (bus_req.htrans == NONSEQ || bus_req.htrans == SEQ);

    // a new transfer may start in the last error cycle
    always_comb begin
        case (state)
            ERR1:    state_nxt = ERR2;
            default: state_nxt = xfer ? ERR1 : IDLE;
        endcase
    end

    always_ff @(posedge XTAL or negedge run) begin
        if (!run) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        rsp.hrdata = '0;
        rsp.hready = (state != ERR1);
        rsp.hresp  = (state == ERR1) || (state == ERR2);
    end

    // a wait cycle is always followed by the final error cycle
    a_err_two_cycle : assert property (
        @(posedge XTAL) disable iff (!run)
        !rsp.hready |-> rsp.hresp ##1 (rsp.hready && rsp.hresp)
    ) else $error("broken two cycle error response");

endmodule

/* hdl/soc_top.sv */
// system top level
// startup sequencer, bus interconnect, ram, gpio and default slave
// behind an external AHB-Lite master port
module soc_top
    import soc_pkg::*;
(
    input  logic              XTAL,
    input  logic              NRST,
    input  ahb_req_t          bus_req,
    output ahb_rsp_t          bus_rsp,
    output logic              run,
    input  logic [GPIO_W-1:0] gpio_in,
    output logic [GPIO_W-1:0] gpio_out,
    output logic [GPIO_W-1:0] gpio_oe
);

    logic     sel_ram;
    logic     sel_gpio;
    logic     sel_def;
    logic     hready;
    ahb_rsp_t rsp_ram;
    ahb_rsp_t rsp_gpio;
    ahb_rsp_t rsp_def;

    // run doubles as the bus reset
    startup_seq u_startup (
        .XTAL     (XTAL),
        .NRST     (NRST),
        .run      (run)
    );

    ahb_interconnect u_ic (
        .XTAL     (XTAL),
        .run      (run),
        .bus_req  (bus_req),
        .sel_ram  (sel_ram),
        .sel_gpio (sel_gpio),
        .sel_def  (sel_def),
        .rsp_ram  (rsp_ram),
        .rsp_gpio (rsp_gpio),
        .rsp_def  (rsp_def),
        .hready   (hready),
        .bus_rsp  (bus_rsp)
    );

    ahb_ram u_ram (
        .XTAL     (XTAL),
        .run      (run),
        .sel      (sel_ram),
        .hready   (hready),
        .bus_req  (bus_req),
        .rsp      (rsp_ram)
    );

    ahb_gpio u_gpio (
        .XTAL     (XTAL),
        .run      (run),
        .sel      (sel_gpio),
        .hready   (hready),
        .bus_req  (bus_req),
        .rsp      (rsp_gpio),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe)
    );

    ahb_default_slave u_def (
        .XTAL     (XTAL),
        .run      (run),
        .sel      (sel_def),
        .hready   (hready),
        .bus_req  (bus_req),
        .rsp      (rsp_def)
    );

endmodule

/* bench/tb_soc.sv */
// system bus testbench
// replays the golden transfer list through a pipelined AHB-Lite master
// and checks read data, responses, wait states and the gpio pins
module tb_soc
    import soc_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HREADY_TIMEOUT = 16;
    localparam int POLL_MAX       = 8;

    typedef struct packed {
        logic [7:0]  op;
        logic [31:0] addr;
        logic [2:0]  size;
        logic [31:0] data;
        logic [31:0] exp;
        logic        resp;
    } line_t;

    logic              XTAL;
    logic              NRST;
    ahb_req_t          bus_req;
    ahb_rsp_t          bus_rsp;
    logic              run;
    logic [GPIO_W-1:0] gpio_in;
    logic [GPIO_W-1:0] gpio_out;
    logic [GPIO_W-1:0] gpio_oe;

    // pins as seen at the start of the last bus cycle
    logic [GPIO_W-1:0] pin_out_s;
    logic [GPIO_W-1:0] pin_oe_s;

    int    cur_test;
    int    errs;
    int    n_pass;
    int    n_fail;
    line_t ops[$];

    soc_top u_dut (
        .XTAL     (XTAL),
        .NRST     (NRST),
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp),
        .run      (run),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe)
    );

    always #10 XTAL = ~XTAL;

    // ------------------------------
    // bus master
    // ------------------------------
    // drives the address phase of a new transfer over the data phase of the
    // previous one and returns once that data phase has ended
    task automatic bus_step(
        input  logic        act,
        input  logic [31:0] addr,
        input  logic [2:0]  size,
        input  logic        wr,
        input  logic [31:0] wdata,
        output logic [31:0] rdata,
        output logic        resp,
        output int          waits
    );
        @(negedge XTAL);
        pin_out_s      = gpio_out;
        pin_oe_s       = gpio_oe;
        bus_req.haddr  = addr;
        bus_req.htrans = act ? NONSEQ : IDLE;
        bus_req.hsize  = hsize_e'(size);
        bus_req.hwrite = wr;
        bus_req.hwdata = wdata;
        waits = 0;
        while (!bus_rsp.hready && waits < HREADY_TIMEOUT) begin
            @(negedge XTAL);
            waits++;
        end
        if (!bus_rsp.hready) begin
            $display("timeout in test %0d, hready stayed low for %0d cycles", cur_test, waits);
            $display("Verification failed");
            $finish;
        end else begin
            rdata = bus_rsp.hrdata;
            resp  = bus_rsp.hresp;
            @(posedge XTAL);
        end
    endtask

    // ------------------------------
    // checks
    // ------------------------------
    task automatic check_xfer(input line_t l, input logic [31:0] rdata, input logic resp,
                              input int waits);
        if (resp !== l.resp) begin
            $display("FAIL test %0d hresp addr %h expected %h actual %h",
                     cur_test, l.addr, l.resp, resp);
            errs++;
        end
        // an ERROR costs exactly one wait state and everything else none
        if (waits != (l.resp ? 1 : 0)) begin
            $display("FAIL test %0d hready low cycles addr %h expected %h actual %h",
                     cur_test, l.addr, (l.resp ? 1 : 0), waits);
            errs++;
        end
        if (l.op == "R" && rdata !== l.exp) begin
            $display("FAIL test %0d hrdata addr %h expected %h actual %h",
                     cur_test, l.addr, l.exp, rdata);
            errs++;
        end
    endtask

    task automatic check_pins(input line_t l, input logic [GPIO_W-1:0] pout,
                              input logic [GPIO_W-1:0] poe);
        if (l.op == "W" && l.addr[31:12] == GPIO_BASE && !l.resp) begin
            if (l.addr[11:0] == GPIO_DATAOUT && pout !== l.data[GPIO_W-1:0]) begin
                $display("FAIL test %0d gpio_out expected %h actual %h",
                         cur_test, l.data[GPIO_W-1:0], pout);
                errs++;
            end
            if (l.addr[11:0] == GPIO_OUTEN && poe !== l.data[GPIO_W-1:0]) begin
                $display("FAIL test %0d gpio_oe expected %h actual %h",
                         cur_test, l.data[GPIO_W-1:0], poe);
                errs++;
            end
        end
    endtask

    // random pin pattern and then reads of GPIO_DATA until the sync catches up
    task automatic poll_gpio(input line_t l);
        logic [GPIO_W-1:0] pat;
        logic [31:0]       rdata;
        logic              resp;
        int                waits;
        bit                hit;
        pat     = GPIO_W'($urandom);
        gpio_in = pat;
        hit     = 1'b0;
        rdata   = '0;
        for (int k = 0; k < POLL_MAX && !hit; k++) begin
            bus_step(1'b1, l.addr, 3'd2, 1'b0, '0, rdata, resp, waits);
            bus_step(1'b0, l.addr, 3'd2, 1'b0, '0, rdata, resp, waits);
            hit = (rdata[GPIO_W-1:0] == pat) && !resp;
        end
        if (!hit) begin
            $display("FAIL test %0d hrdata GPIO_DATA expected %h actual %h",
                     cur_test, pat, rdata[GPIO_W-1:0]);
            errs++;
        end
    endtask

    task automatic finish_test(input string what);
        if (errs == 0) begin
            $display("test %0d %s: ok", cur_test, what);
            n_pass++;
        end else begin
            $display("test %0d %s: %0d errors", cur_test, what, errs);
            n_fail++;
        end
    endtask

    // ------------------------------
    // tests
    // ------------------------------
    task automatic check_startup();
        logic exp_run;
        cur_test = 0;
        errs     = 0;
        repeat (8) @(posedge XTAL);
        @(negedge XTAL);
        if (run !== 1'b0) begin
            $display("FAIL test 0 run in reset expected %h actual %h", 1'b0, run);
            errs++;
        end
        NRST = 1'b1;
        // run rises on the STARTUP_CYCLES-th rising edge, never before
        for (int k = 1; k <= STARTUP_CYCLES; k++) begin
            @(negedge XTAL);
            exp_run = (k == STARTUP_CYCLES);
            if (run !== exp_run) begin
                $display("FAIL test 0 run after edge %0d expected %h actual %h",
                         k, exp_run, run);
                errs++;
            end
            if (bus_rsp.hready !== 1'b1) begin
                $display("FAIL test 0 hready after edge %0d expected %h actual %h",
                         k, 1'b1, bus_rsp.hready);
                errs++;
            end
        end
        finish_test("startup");
    endtask

    task automatic run_test(input int num);
        line_t       prev;
        line_t       done;
        line_t       cur;
        logic        have_prev;
        logic        have_done;
        logic        act;
        logic [31:0] rdata;
        logic        resp;
        int          waits;
        cur_test  = num;
        errs      = 0;
        prev      = '0;
        done      = '0;
        have_prev = 1'b0;
        have_done = 1'b0;
        for (int i = 0; i <= ops.size(); i++) begin
            cur = (i < ops.size()) ? ops[i] : '0;
            act = (i < ops.size()) && (cur.op != "P");
            bus_step(act, cur.addr, cur.size, cur.op == "W", prev.data, rdata, resp, waits);
            if (have_done) begin
                check_pins(done, pin_out_s, pin_oe_s);
            end
            have_done = have_prev;
            done      = prev;
            if (have_prev) begin
                check_xfer(prev, rdata, resp, waits);
            end
            prev      = cur;
            have_prev = act;
            // pin stimulus goes in with the pipeline drained
            if (i < ops.size() && cur.op == "P") begin
                @(negedge XTAL);
                if (have_done) begin
                    check_pins(done, gpio_out, gpio_oe);
                end
                have_done = 1'b0;
                poll_gpio(cur);
            end
        end
        // one more idle cycle so the last write reaches the pins
        bus_step(1'b0, '0, 3'd2, 1'b0, '0, rdata, resp, waits);
        if (have_done) begin
            check_pins(done, pin_out_s, pin_oe_s);
        end
        finish_test("transfers");
    endtask

    initial begin
        int               fd;
        int               num;
        int               size;
        int               resp;
        logic [7:0]       op;
        logic [31:0]      addr;
        logic [31:0]      data;
        logic [31:0]      exp;
        logic [8*128-1:0] text;
        line_t            l;
        void'($urandom(4965));
        XTAL    = 1'b0;
        NRST    = 1'b0;
        bus_req = '0;
        gpio_in = '0;
        n_pass  = 0;
        n_fail  = 0;
        check_startup();
        fd = $fopen("bench/soc_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden file bench/soc_golden.txt");
            n_fail++;
        end else begin
            // header lines do not parse and are skipped
            while (!$feof(fd)) begin
                text = '0;
                if ($fgets(text, fd) > 0 &&
                    $sscanf(text, "%d %s %h %d %h %h %d",
                            num, op, addr, size, data, exp, resp) == 7) begin
                    if (op == "E") begin
                        run_test(num);
                        ops.delete();
                    end else begin
                        l = '{op, addr, size[2:0], data, exp, resp[0]};
                        ops.push_back(l);
                    end
                end
            end
            $fclose(fd);
        end
        $display("summary: %0d tests ok, %0d tests with errors", n_pass, n_fail);
        if (n_fail == 0 && n_pass > 1) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* bench/soc_golden.txt */
# test op addr size data expected resp   (hex: addr data expected; size 0 byte 1 half 2 word)
# op W write, R read, P random pin pattern then poll GPIO_DATA, E end of test
1 W 20000000 2 11223344 00000000 0
1 W 20000004 2 a5a55a5a 00000000 0
1 R 20000004 2 00000000 a5a55a5a 0
1 W 20000ffc 2 deadbeef 00000000 0
1 R 20000000 2 00000000 11223344 0
1 R 20000ffc 2 00000000 deadbeef 0
1 E 00000000 0 00000000 00000000 0
2 W 20000010 2 01234567 00000000 0
2 W 20000011 0 0000aa00 00000000 0
2 W 20000012 1 bbcc0000 00000000 0
2 R 20000010 2 00000000 bbccaa67 0
2 W 20000013 0 ee000000 00000000 0
2 W 20000010 1 00001122 00000000 0
2 R 20000010 2 00000000 eecc1122 0
2 E 00000000 0 00000000 00000000 0
3 W 40000004 2 0000beef 00000000 0
3 W 40000010 2 0000ff00 00000000 0
3 R 40000004 2 00000000 0000beef 0
3 R 40000010 2 00000000 0000ff00 0
3 P 40000000 2 00000000 00000000 0
3 E 00000000 0 00000000 00000000 0
4 W 20000100 2 cafef00d 00000000 0
4 R 30000000 2 00000000 00000000 1
4 W 50000000 2 12345678 00000000 1
4 R 20000100 2 00000000 cafef00d 0
4 E 00000000 0 00000000 00000000 0

/* vlog.f */
hdl/soc_pkg.sv
hdl/startup_seq.sv
hdl/ahb_interconnect.sv
hdl/ahb_ram.sv
hdl/ahb_gpio.sv
hdl/ahb_default_slave.sv
hdl/soc_top.sv
bench/tb_soc.sv
